// ==== Bender.yml ====
package:
  name: two_bank_cache

sources:
  - include_dirs:
      - logic
    files:
      - logic/cache_types_pkg.sv
      - logic/mshr_buffer.sv
      - logic/cache_bank.sv
      - logic/bank_port_arbiter.sv
      - logic/cache_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/cache_tb.sv

// ==== list.f ====
+incdir+logic
logic/cache_types_pkg.sv
logic/mshr_buffer.sv
logic/cache_bank.sv
logic/bank_port_arbiter.sv
logic/cache_top.sv
verif/cache_tb.sv

// ==== logic/bank_port_arbiter.sv ====
`timescale 1ns/1ps
`include "cache_consts.svh"

module bank_port_arbiter (
    input  logic                                          CLK,
    input  logic                                          nRST,
    input  logic [`CACHE_NUM_BANKS-1:0]                   bank_ren,
    input  logic [`CACHE_NUM_BANKS-1:0]                   bank_wen,
    input  cache_types_pkg::addr_t [`CACHE_NUM_BANKS-1:0] bank_addr,
    input  cache_types_pkg::word_t [`CACHE_NUM_BANKS-1:0] bank_store,
    input  cache_types_pkg::uuid_t [`CACHE_NUM_BANKS-1:0] bank_uuid,
    input  logic [`CACHE_NUM_BANKS-1:0]                   bank_uuid_ready,
    input  logic [`CACHE_NUM_BANKS-1:0]                   bank_hit,
    input  cache_types_pkg::word_t [`CACHE_NUM_BANKS-1:0] bank_data,
    input  logic [`CACHE_NUM_BANKS-1:0]                   bank_stall,
    input  logic                                          ram_complete,
    input  cache_types_pkg::word_t                        ram_data,
    output logic [`CACHE_NUM_BANKS-1:0]                   bank_complete,
    output cache_types_pkg::word_t [`CACHE_NUM_BANKS-1:0] bank_ram_data,
    output logic                                          ram_ren,
    output logic                                          ram_wen,
    output cache_types_pkg::addr_t                        ram_addr,
    output cache_types_pkg::word_t                        ram_store,
    output logic                                          hit,
    output cache_types_pkg::word_t                        load_data,
    output logic                                          stall,
    output cache_types_pkg::uuid_t                        uuid_out,
    output logic                                          uuid_ready
);

    logic [`CACHE_BANKS_LEN-1:0] grant_q, next_grant;
    logic [`CACHE_NUM_BANKS-1:0] bank_req;

    assign bank_req = bank_ren | bank_wen;

    // round robin, only while the owner has let go of the port.
    always_comb begin
        next_grant = grant_q;
        if (!bank_req[grant_q]) begin
            for (int i = `CACHE_NUM_BANKS - 1; i >= 1; i--) begin
                if (bank_req[grant_q + i[`CACHE_BANKS_LEN-1:0]]) begin
                    next_grant = grant_q + i[`CACHE_BANKS_LEN-1:0];
                end
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) grant_q <= '0;
        else grant_q <= next_grant;
    end

    assign ram_ren   = bank_ren[grant_q];
    assign ram_wen   = bank_wen[grant_q];
    assign ram_addr  = bank_addr[grant_q];
    assign ram_store = bank_store[grant_q];

    always_comb begin
        bank_complete = '0;
        bank_ram_data = '0;
        bank_complete[grant_q] = ram_complete;
        bank_ram_data[grant_q] = ram_data;
    end

    // bank outputs are zero unless selected, so an OR merges them.
    always_comb begin
        load_data = '0;
        uuid_out = '0;
        for (int b = 0; b < `CACHE_NUM_BANKS; b++) begin
            load_data = load_data | bank_data[b];
            uuid_out = uuid_out | bank_uuid[b];
        end
    end

    assign hit        = |bank_hit;
    assign stall      = |bank_stall;
    assign uuid_ready = |bank_uuid_ready;

endmodule

// ==== logic/cache_bank.sv ====
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_bank (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    bank_instr_valid,
    input  cache_types_pkg::addr_t  instr_addr,
    input  logic                    rw_mode,
    input  cache_types_pkg::word_t  store_value,
    input  cache_types_pkg::mshr_reg mshr_entry,
    input  cache_types_pkg::word_t  ram_mem_data,
    input  logic                    ram_mem_complete,
    output logic                    cache_bank_busy,
    output logic                    scheduler_hit,
    output cache_types_pkg::word_t  scheduler_data_out,
    output logic                    ram_mem_ren,
    output logic                    ram_mem_wen,
    output cache_types_pkg::addr_t  ram_mem_addr,
    output cache_types_pkg::word_t  ram_mem_store,
    output cache_types_pkg::uuid_t  scheduler_uuid_out,
    output logic                    scheduler_uuid_ready
);

    cache_types_pkg::cache_set [`CACHE_SETS_PER_BANK-1:0] bank_q;
    cache_types_pkg::lru_frame [`CACHE_SETS_PER_BANK-1:0] lru_q, next_lru;
    cache_types_pkg::cache_frame                          victim_q;
    cache_types_pkg::word_t [`CACHE_BLOCK_SIZE-1:0]       pull_q;
    cache_types_pkg::bank_fsm_state                       curr_state, next_state;

    logic [`CACHE_BLOCK_OFF_LEN-1:0]            count_q;
    logic [`CACHE_WAYS_LEN-1:0]                 hit_way, victim_way_q, lru_way;
    logic [`CACHE_INDEX_LEN-`CACHE_BANKS_LEN-1:0] set_index, miss_set;
    logic                                       fill_start, count_en, last_beat;

    function automatic cache_types_pkg::lru_frame lru_touch(
        input cache_types_pkg::lru_frame f,
        input logic [`CACHE_WAYS_LEN-1:0] way
    );
        cache_types_pkg::lru_frame r;
        logic [`CACHE_AGE_W-1:0]   oldest;
        r = f;
        oldest = '0;
        r.lru_way = '0;
        for (int j = 0; j < `CACHE_NUM_WAYS; j++) begin
            if (j == way) r.age[j] = '0;
            else if (f.age[j] != '1) r.age[j] = f.age[j] + 1'b1;
            if (r.age[j] > oldest) begin  // strict compare keeps the lower way on a tie.
                oldest = r.age[j];
                r.lru_way = j[`CACHE_WAYS_LEN-1:0];
            end
        end
        return r;
    endfunction

    assign set_index  = instr_addr.fields.index[`CACHE_INDEX_LEN-1:`CACHE_BANKS_LEN];
    assign miss_set   = mshr_entry.block_addr.fields.index[`CACHE_INDEX_LEN-1:`CACHE_BANKS_LEN];
    assign lru_way    = lru_q[miss_set].lru_way;
    assign fill_start = (curr_state == cache_types_pkg::START) && mshr_entry.valid;
    assign count_en   = ram_mem_complete && ((curr_state == cache_types_pkg::BLOCK_PULL) ||
                                             (curr_state == cache_types_pkg::VICTIM_EJECT));
    assign last_beat  = count_en && (count_q == `CACHE_BLOCK_OFF_LEN'(`CACHE_BLOCK_SIZE - 1));

    // --------------------
    // lookup
    // --------------------
    always_comb begin
        scheduler_hit = 1'b0;
        hit_way = '0;
        scheduler_data_out = '0;
        for (int i = 0; i < `CACHE_NUM_WAYS; i++) begin
            // the way being evicted this cycle must not take a hit.
            if (bank_instr_valid && bank_q[set_index][i].valid &&
                    (bank_q[set_index][i].tag == instr_addr.fields.tag) &&
                    !(fill_start && (set_index == miss_set) && (i == lru_way))) begin
                scheduler_hit = 1'b1;
                hit_way = i[`CACHE_WAYS_LEN-1:0];
                scheduler_data_out = bank_q[set_index][i].block[instr_addr.fields.block_offset];
            end
        end
    end

    always_comb begin
        next_lru = lru_q;
        if (scheduler_hit) next_lru[set_index] = lru_touch(next_lru[set_index], hit_way);
        if (curr_state == cache_types_pkg::FINISH) begin
            next_lru[miss_set] = lru_touch(next_lru[miss_set], victim_way_q);
        end
    end

    // --------------------
    // fill and eject
    // --------------------
    always_comb begin
        next_state = curr_state;
        case (curr_state)
            cache_types_pkg::START:
                if (mshr_entry.valid) next_state = cache_types_pkg::BLOCK_PULL;
            cache_types_pkg::BLOCK_PULL:
                if (last_beat) begin
                    next_state = (victim_q.valid && victim_q.dirty) ?
                                 cache_types_pkg::VICTIM_EJECT : cache_types_pkg::FINISH;
                end
            cache_types_pkg::VICTIM_EJECT:
                if (last_beat) next_state = cache_types_pkg::FINISH;
            default: next_state = cache_types_pkg::START;
        endcase
    end

    always_comb begin
        ram_mem_addr = '0;
        ram_mem_addr.fields.tag = (curr_state == cache_types_pkg::VICTIM_EJECT) ?
                                  victim_q.tag : mshr_entry.block_addr.fields.tag;
        ram_mem_addr.fields.index = mshr_entry.block_addr.fields.index;  // victim shares the set.
        ram_mem_addr.fields.block_offset = count_q;
    end

    assign ram_mem_ren          = (curr_state == cache_types_pkg::BLOCK_PULL);
    assign ram_mem_wen          = (curr_state == cache_types_pkg::VICTIM_EJECT);
    assign ram_mem_store        = ram_mem_wen ? victim_q.block[count_q] : '0;
    assign cache_bank_busy      = fill_start || (curr_state == cache_types_pkg::BLOCK_PULL);
    assign scheduler_uuid_ready = (curr_state == cache_types_pkg::FINISH);
    assign scheduler_uuid_out   = scheduler_uuid_ready ? mshr_entry.uuid : '0;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            curr_state <= cache_types_pkg::START;
            count_q <= '0;
            bank_q <= '0;
            lru_q <= '0;
            victim_way_q <= '0;
        end else begin
            curr_state <= next_state;
            lru_q <= next_lru;
            if (count_en) count_q <= count_q + 1'b1;  // wraps to zero after the last beat.
            if (scheduler_hit && rw_mode) begin
                bank_q[set_index][hit_way].block[instr_addr.fields.block_offset] <= store_value;
                bank_q[set_index][hit_way].dirty <= 1'b1;
            end
            if (fill_start) begin
                victim_way_q <= lru_way;
                bank_q[miss_set][lru_way].valid <= 1'b0;
            end
            if (curr_state == cache_types_pkg::FINISH) begin
                bank_q[miss_set][victim_way_q].valid <= 1'b1;
                bank_q[miss_set][victim_way_q].dirty <= |mshr_entry.write_status;
                bank_q[miss_set][victim_way_q].tag <= mshr_entry.block_addr.fields.tag;
                for (int w = 0; w < `CACHE_BLOCK_SIZE; w++) begin
                    // merged store words override what came back from RAM.
                    bank_q[miss_set][victim_way_q].block[w] <= mshr_entry.write_status[w] ?
                        mshr_entry.write_block[w] : pull_q[w];
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fill_start) victim_q <= bank_q[miss_set][lru_way];
        if ((curr_state == cache_types_pkg::BLOCK_PULL) && ram_mem_complete) begin
            pull_q[count_q] <= ram_mem_data;
        end
    end

endmodule

// ==== logic/cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

`define CACHE_WORD_W        32
`define CACHE_NUM_BANKS     2
`define CACHE_BANKS_LEN     1
`define CACHE_NUM_WAYS      2
`define CACHE_WAYS_LEN      1
`define CACHE_NUM_SETS      8
`define CACHE_SETS_PER_BANK 4
`define CACHE_INDEX_LEN     3   // low bit picks the bank.
`define CACHE_BLOCK_SIZE    4
`define CACHE_BLOCK_OFF_LEN 2
`define CACHE_TAG_LEN       25
`define CACHE_UUID_W        4
`define CACHE_AGE_W         4   // saturating age counter.

`endif

// ==== logic/cache_top.sv ====
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_top (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   instr_valid,
    input  cache_types_pkg::addr_t instr_addr,
    input  logic                   rw_mode,
    input  cache_types_pkg::word_t store_value,
    input  cache_types_pkg::uuid_t instr_uuid,
    output logic                   hit,
    output cache_types_pkg::word_t load_data,
    output logic                   stall,
    output cache_types_pkg::uuid_t uuid_out,
    output logic                   uuid_ready,
    output logic                   ram_ren,
    output logic                   ram_wen,
    output cache_types_pkg::addr_t ram_addr,
    output cache_types_pkg::word_t ram_store,
    input  cache_types_pkg::word_t ram_data,
    input  logic                   ram_complete
);

    cache_types_pkg::mshr_reg [`CACHE_NUM_BANKS-1:0] mshr_entry;
    cache_types_pkg::addr_t [`CACHE_NUM_BANKS-1:0]   bank_addr;
    cache_types_pkg::word_t [`CACHE_NUM_BANKS-1:0]   bank_store, bank_data, bank_ram_data;
    cache_types_pkg::uuid_t [`CACHE_NUM_BANKS-1:0]   bank_uuid;
    logic [`CACHE_NUM_BANKS-1:0] bank_instr_valid, bank_hit, bank_busy, bank_uuid_ready;
    logic [`CACHE_NUM_BANKS-1:0] bank_stall, bank_ren, bank_wen, bank_complete;

    for (genvar b = 0; b < `CACHE_NUM_BANKS; b++) begin : g_bank
        mshr_buffer #(.bank_id(b)) mshr_i (
            .CLK              (CLK),
            .nRST             (nRST),
            .instr_valid      (instr_valid),
            .instr_addr       (instr_addr),
            .rw_mode          (rw_mode),
            .store_value      (store_value),
            .instr_uuid       (instr_uuid),
            .scheduler_hit    (bank_hit[b]),
            .cache_bank_busy  (bank_busy[b]),
            .uuid_ready       (bank_uuid_ready[b]),
            .bank_instr_valid (bank_instr_valid[b]),
            .mshr_entry       (mshr_entry[b]),
            .stall            (bank_stall[b])
        );

        cache_bank bank_i (
            .CLK                  (CLK),
            .nRST                 (nRST),
            .bank_instr_valid     (bank_instr_valid[b]),
            .instr_addr           (instr_addr),
            .rw_mode              (rw_mode),
            .store_value          (store_value),
            .mshr_entry           (mshr_entry[b]),
            .ram_mem_data         (bank_ram_data[b]),
            .ram_mem_complete     (bank_complete[b]),
            .cache_bank_busy      (bank_busy[b]),
            .scheduler_hit        (bank_hit[b]),
            .scheduler_data_out   (bank_data[b]),
            .ram_mem_ren          (bank_ren[b]),
            .ram_mem_wen          (bank_wen[b]),
            .ram_mem_addr         (bank_addr[b]),
            .ram_mem_store        (bank_store[b]),
            .scheduler_uuid_out   (bank_uuid[b]),
            .scheduler_uuid_ready (bank_uuid_ready[b])
        );
    end

    bank_port_arbiter arbiter_i (
        .CLK             (CLK),
        .nRST            (nRST),
        .bank_ren        (bank_ren),
        .bank_wen        (bank_wen),
        .bank_addr       (bank_addr),
        .bank_store      (bank_store),
        .bank_uuid       (bank_uuid),
        .bank_uuid_ready (bank_uuid_ready),
        .bank_hit        (bank_hit),
        .bank_data       (bank_data),
        .bank_stall      (bank_stall),
        .ram_complete    (ram_complete),
        .ram_data        (ram_data),
        .bank_complete   (bank_complete),
        .bank_ram_data   (bank_ram_data),
        .ram_ren         (ram_ren),
        .ram_wen         (ram_wen),
        .ram_addr        (ram_addr),
        .ram_store       (ram_store),
        .hit             (hit),
        .load_data       (load_data),
        .stall           (stall),
        .uuid_out        (uuid_out),
        .uuid_ready      (uuid_ready)
    );

endmodule

// ==== logic/cache_types_pkg.sv ====
`include "cache_consts.svh"

package cache_types_pkg;

    typedef logic [`CACHE_WORD_W-1:0] word_t;
    typedef logic [`CACHE_UUID_W-1:0] uuid_t;

    typedef struct packed {
        logic [`CACHE_TAG_LEN-1:0]       tag;
        logic [`CACHE_INDEX_LEN-1:0]     index;
        logic [`CACHE_BLOCK_OFF_LEN-1:0] block_offset;
        logic [1:0]                      byte_offset;
    } addr_fields_t;

    // one address word, seen flat on the RAM port and split for lookup.
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t fields;
    } addr_t;

    typedef struct packed {
        logic                                valid;
        logic                                dirty;
        logic [`CACHE_TAG_LEN-1:0]           tag;
        word_t [`CACHE_BLOCK_SIZE-1:0]       block;
    } cache_frame;

    typedef cache_frame [`CACHE_NUM_WAYS-1:0] cache_set;

    typedef struct packed {
        logic [`CACHE_NUM_WAYS-1:0][`CACHE_AGE_W-1:0] age;
        logic [`CACHE_WAYS_LEN-1:0]                   lru_way;
    } lru_frame;

    typedef struct packed {
        logic                          valid;
        uuid_t                         uuid;
        addr_t                         block_addr;
        logic [`CACHE_BLOCK_SIZE-1:0]  write_status;  // words already written by stores.
        word_t [`CACHE_BLOCK_SIZE-1:0] write_block;
    } mshr_reg;

    typedef enum logic [1:0] {START, BLOCK_PULL, VICTIM_EJECT, FINISH} bank_fsm_state;

endpackage

// ==== logic/mshr_buffer.sv ====
`timescale 1ns/1ps
`include "cache_consts.svh"

module mshr_buffer #(
    parameter int bank_id = 0
) (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     instr_valid,
    input  cache_types_pkg::addr_t   instr_addr,
    input  logic                     rw_mode,
    input  cache_types_pkg::word_t   store_value,
    input  cache_types_pkg::uuid_t   instr_uuid,
    input  logic                     scheduler_hit,
    input  logic                     cache_bank_busy,
    input  logic                     uuid_ready,
    output logic                     bank_instr_valid,
    output cache_types_pkg::mshr_reg mshr_entry,
    output logic                     stall
);

    cache_types_pkg::mshr_reg entry_q;
    logic                     miss, same_block, merge;

    assign bank_instr_valid = instr_valid && (instr_addr.fields.index[`CACHE_BANKS_LEN-1:0] ==
                                              bank_id[`CACHE_BANKS_LEN-1:0]);
    assign miss       = bank_instr_valid && !scheduler_hit;
    assign same_block = (instr_addr.fields.tag == entry_q.block_addr.fields.tag) &&
                        (instr_addr.fields.index == entry_q.block_addr.fields.index);
    // a store to the block still being pulled is folded into the entry.
    assign merge      = miss && entry_q.valid && rw_mode && same_block && cache_bank_busy;
    assign stall      = miss && entry_q.valid && !merge;
    assign mshr_entry = entry_q;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            entry_q <= '0;
        end else if (uuid_ready) begin
            entry_q.valid <= 1'b0;
        end else if (miss && !entry_q.valid) begin
            entry_q.valid <= 1'b1;
            entry_q.uuid <= instr_uuid;
            entry_q.block_addr <= instr_addr;
            entry_q.block_addr.fields.block_offset <= '0;
            entry_q.block_addr.fields.byte_offset <= '0;
            entry_q.write_status <= '0;
            if (rw_mode) begin
                entry_q.write_status[instr_addr.fields.block_offset] <= 1'b1;
                entry_q.write_block[instr_addr.fields.block_offset] <= store_value;
            end
        end else if (merge) begin
            entry_q.write_status[instr_addr.fields.block_offset] <= 1'b1;
            entry_q.write_block[instr_addr.fields.block_offset] <= store_value;
        end
    end

endmodule

// ==== verif/cache_tb.sv ====
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_tb;

    localparam int OP_LD        = 0;
    localparam int OP_ST        = 1;
    localparam int OP_WAIT      = 2;  // wait for uuid_ready and compare the uuid.
    localparam int OP_MEM       = 3;  // compare a word held by the RAM model.
    localparam int MAX_ROWS     = 32;
    localparam int RAM_WORDS    = 1024;
    localparam int UUID_TIMEOUT = 200;

    logic                   CLK, nRST, instr_valid, rw_mode;
    cache_types_pkg::addr_t instr_addr, ram_addr;
    cache_types_pkg::word_t store_value, load_data, ram_store, ram_data;
    cache_types_pkg::uuid_t instr_uuid, uuid_out;
    logic                   hit, stall, uuid_ready, ram_ren, ram_wen, ram_complete;

    cache_types_pkg::word_t ram_mem [RAM_WORDS];
    integer                 seed;
    int                     beat_wait, read_beats, fills, num_rows;

    int                     row_op     [MAX_ROWS];
    cache_types_pkg::addr_t row_addr   [MAX_ROWS];
    cache_types_pkg::word_t row_value  [MAX_ROWS];
    cache_types_pkg::word_t row_data   [MAX_ROWS];
    cache_types_pkg::uuid_t row_uuid   [MAX_ROWS];
    logic                   row_hit    [MAX_ROWS];
    logic                   row_stall  [MAX_ROWS];
    logic                   row_replay [MAX_ROWS];

    cache_top cache_top_i (
        .CLK(CLK), .nRST(nRST), .instr_valid(instr_valid), .instr_addr(instr_addr),
        .rw_mode(rw_mode), .store_value(store_value), .instr_uuid(instr_uuid),
        .hit(hit), .load_data(load_data), .stall(stall), .uuid_out(uuid_out),
        .uuid_ready(uuid_ready), .ram_ren(ram_ren), .ram_wen(ram_wen), .ram_addr(ram_addr),
        .ram_store(ram_store), .ram_data(ram_data), .ram_complete(ram_complete)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // words never written read back as the address xor a fixed mask.
    function automatic cache_types_pkg::word_t ram_rule(input cache_types_pkg::word_t addr);
        return addr ^ 32'h5a5a_0000;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input cache_types_pkg::word_t got,
                              input cache_types_pkg::word_t exp);
        if (got !== exp) abort_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) abort_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_uuid(input string name, input cache_types_pkg::uuid_t got,
                              input cache_types_pkg::uuid_t exp);
        if (got !== exp) abort_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    endtask

    // --------------------
    // RAM model
    // --------------------
    initial begin
        seed = 32'hdd45_0a06;
        ram_complete = 1'b0;
        ram_data = '0;
        read_beats = 0;
        for (int i = 0; i < RAM_WORDS; i++) ram_mem[i] = ram_rule(i * 4);
        beat_wait = 1 + {$random(seed)} % 3;
        forever begin
            @(negedge CLK);
            if (ram_complete) begin
                ram_complete = 1'b0;  // one-cycle beat pulse.
                beat_wait = 1 + {$random(seed)} % 3;
            end else if (nRST && (ram_ren || ram_wen)) begin
                if (ram_addr.raw[31:12] !== '0) begin
                    abort_run("the cache accessed a RAM address outside the modeled range");
                end else if (beat_wait > 1) begin
                    beat_wait--;
                end else begin
                    if (ram_wen) ram_mem[ram_addr.raw[11:2]] = ram_store;
                    else ram_data = ram_mem[ram_addr.raw[11:2]];
                    if (!ram_wen) read_beats++;
                    ram_complete = 1'b1;
                end
            end
        end
    end

    task automatic add_row(input int op, input cache_types_pkg::word_t addr,
                           input cache_types_pkg::word_t value, input cache_types_pkg::uuid_t id,
                           input logic exp_hit, input cache_types_pkg::word_t exp_data,
                           input logic exp_stall, input logic replay);
        row_op[num_rows] = op;
        row_addr[num_rows].raw = addr;
        row_value[num_rows] = value;
        row_uuid[num_rows] = id;
        row_hit[num_rows] = exp_hit;
        row_data[num_rows] = exp_data;
        row_stall[num_rows] = exp_stall;
        row_replay[num_rows] = replay;
        num_rows++;
    endtask

    task automatic build_table();
        num_rows = 0;
        add_row(OP_LD, 32'h100, '0, 4'd1, 1'b0, ram_rule(32'h100), 1'b0, 1'b1);
        add_row(OP_ST, 32'h104, 32'hcafe_0001, 4'd2, 1'b1, '0, 1'b0, 1'b0);
        add_row(OP_LD, 32'h104, '0, 4'd3, 1'b1, 32'hcafe_0001, 1'b0, 1'b0);
        add_row(OP_LD, 32'h180, '0, 4'd4, 1'b0, ram_rule(32'h180), 1'b0, 1'b1);
        add_row(OP_LD, 32'h200, '0, 4'd5, 1'b0, ram_rule(32'h200), 1'b0, 1'b1);  // dirty victim.
        add_row(OP_MEM, 32'h104, 32'hcafe_0001, '0, 1'b0, '0, 1'b0, 1'b0);
        add_row(OP_MEM, 32'h10c, ram_rule(32'h10c), '0, 1'b0, '0, 1'b0, 1'b0);
        add_row(OP_LD, 32'h100, '0, 4'd6, 1'b0, ram_rule(32'h100), 1'b0, 1'b1);
        add_row(OP_LD, 32'h104, '0, 4'd7, 1'b1, 32'hcafe_0001, 1'b0, 1'b0);
        add_row(OP_ST, 32'h314, 32'hbeef_0002, 4'd8, 1'b0, '0, 1'b0, 1'b0);
        add_row(OP_ST, 32'h31c, 32'hbeef_0003, 4'd9, 1'b0, '0, 1'b0, 1'b0);  // merged store.
        add_row(OP_WAIT, '0, '0, 4'd8, 1'b0, '0, 1'b0, 1'b0);
        add_row(OP_LD, 32'h314, '0, 4'd10, 1'b1, 32'hbeef_0002, 1'b0, 1'b0);
        add_row(OP_LD, 32'h31c, '0, 4'd11, 1'b1, 32'hbeef_0003, 1'b0, 1'b0);
        add_row(OP_LD, 32'h310, '0, 4'd12, 1'b1, ram_rule(32'h310), 1'b0, 1'b0);
        add_row(OP_LD, 32'h318, '0, 4'd13, 1'b1, ram_rule(32'h318), 1'b0, 1'b0);
        add_row(OP_LD, 32'h020, '0, 4'd14, 1'b0, '0, 1'b0, 1'b0);
        add_row(OP_LD, 32'h0a0, '0, 4'd15, 1'b0, '0, 1'b1, 1'b0);  // bank 0 is busy.
        add_row(OP_LD, 32'h030, '0, 4'd1, 1'b0, '0, 1'b0, 1'b0);
        add_row(OP_WAIT, '0, '0, 4'd14, 1'b0, '0, 1'b0, 1'b0);
        add_row(OP_WAIT, '0, '0, 4'd1, 1'b0, '0, 1'b0, 1'b0);
        add_row(OP_LD, 32'h020, '0, 4'd2, 1'b1, ram_rule(32'h020), 1'b0, 1'b0);
        add_row(OP_LD, 32'h030, '0, 4'd3, 1'b1, ram_rule(32'h030), 1'b0, 1'b0);
        add_row(OP_LD, 32'h0a0, '0, 4'd4, 1'b0, ram_rule(32'h0a0), 1'b0, 1'b1);
    endtask

    // --------------------
    // request and response
    // --------------------
    task automatic issue(input int r, input logic replaying);
        @(negedge CLK);
        instr_valid = 1'b1;
        instr_addr = row_addr[r];
        rw_mode = (row_op[r] == OP_ST);
        store_value = row_value[r];
        instr_uuid = row_uuid[r];
        #1;
        check_bit("hit", hit, replaying || row_hit[r]);
        check_bit("stall", stall, !replaying && row_stall[r]);
        if ((replaying || row_hit[r]) && !rw_mode) check_word("load_data", load_data, row_data[r]);
        @(negedge CLK);
        instr_valid = 1'b0;
        rw_mode = 1'b0;
    endtask

    task automatic wait_uuid(input cache_types_pkg::uuid_t exp_uuid);
        int   cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < UUID_TIMEOUT) begin
            @(negedge CLK);
            #1;
            seen = uuid_ready;
            cycles++;
        end
        if (!seen) abort_run("timed out waiting for uuid_ready after a miss");
        else check_uuid("uuid_out", uuid_out, exp_uuid);
        fills++;
    endtask

    task automatic run_row(input int r);
        if (row_op[r] == OP_WAIT) begin
            wait_uuid(row_uuid[r]);
        end else if (row_op[r] == OP_MEM) begin
            check_word("ram_mem", ram_mem[row_addr[r].raw[11:2]], row_value[r]);
        end else begin
            issue(r, 1'b0);
            if (row_replay[r]) begin
                wait_uuid(row_uuid[r]);
                issue(r, 1'b1);
            end
        end
    endtask

    initial begin
        nRST = 1'b0;
        instr_valid = 1'b0;
        instr_addr = '0;
        rw_mode = 1'b0;
        store_value = '0;
        instr_uuid = '0;
        fills = 0;
        build_table();
        @(negedge CLK);
        instr_valid = 1'b1;  // a request in reset finds no valid line and no busy entry.
        instr_addr = row_addr[0];
        #1;
        check_bit("hit", hit, 1'b0);
        check_bit("stall", stall, 1'b0);
        @(negedge CLK);
        instr_valid = 1'b0;
        nRST = 1'b1;
        #1;
        check_bit("ram_ren", ram_ren, 1'b0);
        check_bit("ram_wen", ram_wen, 1'b0);
        check_bit("uuid_ready", uuid_ready, 1'b0);
        for (int r = 0; r < num_rows; r++) run_row(r);
        check_word("read beats", read_beats, fills * `CACHE_BLOCK_SIZE);  // every fill pulls a block.
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
